/* rtl/icache_pkg.sv */
// Instruction cache package with geometry, address fields, data types and controller states
package icache_pkg;

  // --------------------
  // Cache geometry
  // --------------------
  localparam int NUM_WAYS   = 6;    // Six-way set-associative
  localparam int NUM_SETS   = 8;    // Eight sets, indexed by three address bits
  localparam int WORD_W     = 32;   // Instruction word and memory beat width
  localparam int ADDR_W     = 32;   // Byte address width
  localparam int LINE_WORDS = 8;    // Words per line, also the burst length
  localparam int LINE_W     = 256;  // LINE_WORDS * WORD_W

  // Address split is tag | index | offset, with the offset covering 32 bytes
  localparam int OFFSET_W   = 5;
  localparam int INDEX_W    = 3;
  localparam int TAG_W      = 24;   // ADDR_W - INDEX_W - OFFSET_W

  // Use stamps are wide enough that tests never reach saturation
  localparam int STAMP_W    = 8;

  // --------------------
  // Data types
  // --------------------
  typedef logic [WORD_W-1:0]            word_t;
  typedef logic [ADDR_W-1:0]            addr_t;
  typedef logic [TAG_W-1:0]             tag_t;
  typedef logic [INDEX_W-1:0]           index_t;
  typedef logic [$clog2(NUM_WAYS)-1:0]  way_t;   // Three bits, ways 0 to 5 used
  typedef logic [LINE_W-1:0]            line_t;  // Word 0 sits in the low bits
  typedef logic [STAMP_W-1:0]           stamp_t;

  // Refill controller states, lookup is the idle state
  typedef enum logic [1:0] {
    ST_LOOKUP,   // Idle, takes a CPU request and looks it up
    ST_MEM_REQ,  // Line request held to memory until accepted
    ST_REFILL    // Taking in the burst beats
  } cache_state_e;

endpackage

/* rtl/icache_tag_store.sv */
// Tag store holding valid bits and tags for every way, with tag compare and hit-way encoding
`timescale 1ns/1ps

module icache_tag_store (
  input  logic              clk,
  input  logic              rst,
  input  icache_pkg::addr_t req_addr,
  input  logic              fill_we,     // Pulse on the last refill beat
  input  icache_pkg::way_t  victim_way,
  output logic              hit,
  output icache_pkg::way_t  hit_way
);

  // Valid bits need a reset, the tags themselves do not
  logic [icache_pkg::NUM_SETS-1:0][icache_pkg::NUM_WAYS-1:0] valid_q;
  icache_pkg::tag_t tag_q [icache_pkg::NUM_SETS][icache_pkg::NUM_WAYS];

  icache_pkg::tag_t              req_tag;
  icache_pkg::index_t            req_index;
  logic [icache_pkg::NUM_WAYS-1:0] way_match;  // One bit per way of the indexed set

  assign req_tag   = req_addr[icache_pkg::ADDR_W-1 -: icache_pkg::TAG_W];
  assign req_index = req_addr[icache_pkg::OFFSET_W +: icache_pkg::INDEX_W];

  // --------------------
  // Array updates
  // --------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;                              // Cache starts empty
    end else if (fill_we) begin
      valid_q[req_index][victim_way] <= 1'b1;     // Line becomes usable once fully written
    end
  end

  always_ff @(posedge clk) begin
    if (fill_we) begin
      tag_q[req_index][victim_way] <= req_tag;    // Held request address supplies the tag
    end
  end

  // --------------------
  // Lookup
  // --------------------
  always_comb begin
    for (int w = 0; w < icache_pkg::NUM_WAYS; w++) begin
      way_match[w] = valid_q[req_index][w] && (tag_q[req_index][w] == req_tag);
    end
  end

  assign hit = |way_match;

  // Walk downwards so the lowest matching way is the one left standing
  always_comb begin
    hit_way = '0;
    for (int w = icache_pkg::NUM_WAYS - 1; w >= 0; w--) begin
      if (way_match[w]) hit_way = icache_pkg::way_t'(w);
    end
  end

endmodule

/* rtl/icache_line_store.sv */
// Line store holding the cache line data of every way and selecting the requested word
`timescale 1ns/1ps

module icache_line_store (
  input  logic              clk,
  input  icache_pkg::addr_t req_addr,
  input  logic              fill_we,     // Whole-line write on the last refill beat
  input  icache_pkg::way_t  victim_way,
  input  icache_pkg::line_t fill_line,
  input  icache_pkg::way_t  hit_way,
  output icache_pkg::word_t rsp_data
);

  // Line arrays, one entry per set and way
  icache_pkg::line_t line_q [icache_pkg::NUM_SETS][icache_pkg::NUM_WAYS];

  icache_pkg::index_t                          req_index;
  logic [$clog2(icache_pkg::LINE_WORDS)-1:0]   word_sel;   // Address bits 4 to 2
  icache_pkg::line_t                           hit_line;

  assign req_index = req_addr[icache_pkg::OFFSET_W +: icache_pkg::INDEX_W];
  assign word_sel  = req_addr[icache_pkg::OFFSET_W-1:2];   // Byte bits 1 to 0 are ignored

  // --------------------
  // Refill write
  // --------------------
  always_ff @(posedge clk) begin
    if (fill_we) begin
      line_q[req_index][victim_way] <= fill_line;  // The whole assembled line in one go
    end
  end

  // --------------------
  // Read path
  // --------------------
  // Purely combinational so a hit answers in the request cycle
  assign hit_line = line_q[req_index][hit_way];
  assign rsp_data = hit_line[word_sel*icache_pkg::WORD_W +: icache_pkg::WORD_W];

endmodule

/* rtl/icache_lru.sv */
// Replacer keeping per-way use stamps and a saturating stamp counter to pick the victim way
`timescale 1ns/1ps

module icache_lru (
  input  logic              clk,
  input  logic              rst,
  input  icache_pkg::addr_t req_addr,
  input  logic              rsp_fire,    // Accepted hit in the lookup state
  input  icache_pkg::way_t  hit_way,
  output icache_pkg::way_t  victim_way
);

  icache_pkg::stamp_t stamp_q [icache_pkg::NUM_SETS][icache_pkg::NUM_WAYS];
  icache_pkg::stamp_t counter_q;   // Global use counter, shared by all sets
  icache_pkg::stamp_t best_stamp;  // Smallest stamp seen while scanning the set
  icache_pkg::index_t req_index;

  assign req_index = req_addr[icache_pkg::OFFSET_W +: icache_pkg::INDEX_W];

  // --------------------
  // Stamp update
  // --------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int s = 0; s < icache_pkg::NUM_SETS; s++) begin
        for (int w = 0; w < icache_pkg::NUM_WAYS; w++) begin
          stamp_q[s][w] <= '0;
        end
      end
      counter_q <= '0;
    end else if (rsp_fire) begin
      stamp_q[req_index][hit_way] <= counter_q;  // Most recent use gets the current count
      // Counter sticks at all ones instead of wrapping back to the oldest value
      if (counter_q != '1) begin
        counter_q <= counter_q + 1'b1;
      end
    end
  end

  // --------------------
  // Victim choice
  // --------------------
  // Strict compare keeps the lowest way on ties, so empty ways fill in order
  always_comb begin
    victim_way = '0;
    best_stamp = stamp_q[req_index][0];
    for (int w = 1; w < icache_pkg::NUM_WAYS; w++) begin
      if (stamp_q[req_index][w] < best_stamp) begin
        best_stamp = stamp_q[req_index][w];
        victim_way = icache_pkg::way_t'(w);
      end
    end
  end

endmodule

/* rtl/icache_refill_ctrl.sv */
// Refill controller running lookup, memory request and refill, and assembling the burst into a line
`timescale 1ns/1ps

module icache_refill_ctrl (
  input  logic              clk,
  input  logic              rst,
  input  logic              req_valid,
  input  icache_pkg::addr_t req_addr,
  input  logic              hit,
  output logic              cpu_req_ready,
  output logic              rsp_fire,
  output logic              mem_req_valid,
  output icache_pkg::addr_t mem_req_addr,
  input  logic              mem_req_ready,
  input  logic              mem_rsp_valid,
  input  icache_pkg::word_t mem_rsp_data,
  input  logic              mem_rsp_last,
  output logic              mem_rsp_ready,
  output logic              fill_we,
  output icache_pkg::line_t fill_line
);

  icache_pkg::cache_state_e state_q;
  icache_pkg::cache_state_e state_d;
  icache_pkg::line_t        line_q;      // Partial line while the burst comes in
  logic                     beat_fire;   // Beat taken this cycle

  // --------------------
  // State machine
  // --------------------
  always_ff @(posedge clk) begin
    if (rst) state_q <= icache_pkg::ST_LOOKUP;  // No init phase, lookup is ready at once
    else     state_q <= state_d;
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      icache_pkg::ST_LOOKUP: begin
        if (req_valid && !hit) state_d = icache_pkg::ST_MEM_REQ;  // Miss goes to memory
      end
      icache_pkg::ST_MEM_REQ: begin
        if (mem_req_ready) state_d = icache_pkg::ST_REFILL;      // Request accepted
      end
      icache_pkg::ST_REFILL: begin
        // Back in lookup the held request sees the new line and hits
        if (beat_fire && mem_rsp_last) state_d = icache_pkg::ST_LOOKUP;
      end
      default: state_d = icache_pkg::ST_LOOKUP;
    endcase
  end

  // --------------------
  // Handshakes
  // --------------------
  assign cpu_req_ready = (state_q == icache_pkg::ST_LOOKUP);
  assign rsp_fire      = cpu_req_ready && req_valid && hit;  // Zero-latency hit
  assign mem_req_valid = (state_q == icache_pkg::ST_MEM_REQ);
  assign mem_rsp_ready = (state_q == icache_pkg::ST_REFILL);  // Memory stalls only stretch refill
  assign beat_fire     = mem_rsp_valid && mem_rsp_ready;

  // Line-aligned address, the CPU keeps req_addr stable for the whole miss
  assign mem_req_addr = {req_addr[icache_pkg::ADDR_W-1:icache_pkg::OFFSET_W],
                         {icache_pkg::OFFSET_W{1'b0}}};

  // --------------------
  // Line assembly
  // --------------------
  // Each beat enters at the top and pushes older words down, so after eight
  // beats the first one has reached word 0
  assign fill_line = {mem_rsp_data, line_q[icache_pkg::LINE_W-1:icache_pkg::WORD_W]};
  assign fill_we   = beat_fire && mem_rsp_last;  // Single pulse, memory always sends eight beats

  always_ff @(posedge clk) begin
    if (beat_fire) begin
      line_q <= fill_line;
    end
  end

endmodule

/* rtl/icache_top.sv */
// Instruction cache top level connecting tag store, line store, replacer and refill controller
`timescale 1ns/1ps

module icache_top (
  input  logic              clk,
  input  logic              rst,
  // CPU fetch side
  input  logic              cpu_req_valid,
  input  icache_pkg::addr_t cpu_req_addr,
  output logic              cpu_req_ready,
  output logic              cpu_rsp_valid,
  output icache_pkg::word_t cpu_rsp_data,
  // Memory read side
  output logic              mem_req_valid,
  output icache_pkg::addr_t mem_req_addr,
  input  logic              mem_req_ready,
  input  logic              mem_rsp_valid,
  input  icache_pkg::word_t mem_rsp_data,
  input  logic              mem_rsp_last,
  output logic              mem_rsp_ready
);

  logic              hit;
  icache_pkg::way_t  hit_way;
  icache_pkg::way_t  victim_way;
  logic              rsp_fire;
  logic              fill_we;
  icache_pkg::line_t fill_line;

  assign cpu_rsp_valid = rsp_fire;  // No response-ready, the CPU always takes it

  // --------------------
  // Storage
  // --------------------
  icache_tag_store i_tag_store (
    .clk        (clk),
    .rst        (rst),
    .req_addr   (cpu_req_addr),
    .fill_we    (fill_we),
    .victim_way (victim_way),
    .hit        (hit),
    .hit_way    (hit_way)
  );

  icache_line_store i_line_store (
    .clk        (clk),
    .req_addr   (cpu_req_addr),
    .fill_we    (fill_we),
    .victim_way (victim_way),
    .fill_line  (fill_line),
    .hit_way    (hit_way),
    .rsp_data   (cpu_rsp_data)
  );

  // --------------------
  // Control
  // --------------------
  icache_lru i_lru (
    .clk        (clk),
    .rst        (rst),
    .req_addr   (cpu_req_addr),
    .rsp_fire   (rsp_fire),
    .hit_way    (hit_way),
    .victim_way (victim_way)
  );

  icache_refill_ctrl i_refill_ctrl (
    .clk           (clk),
    .rst           (rst),
    .req_valid     (cpu_req_valid),
    .req_addr      (cpu_req_addr),
    .hit           (hit),
    .cpu_req_ready (cpu_req_ready),
    .rsp_fire      (rsp_fire),
    .mem_req_valid (mem_req_valid),
    .mem_req_addr  (mem_req_addr),
    .mem_req_ready (mem_req_ready),
    .mem_rsp_valid (mem_rsp_valid),
    .mem_rsp_data  (mem_rsp_data),
    .mem_rsp_last  (mem_rsp_last),
    .mem_rsp_ready (mem_rsp_ready),
    .fill_we       (fill_we),
    .fill_line     (fill_line)
  );

endmodule

/* bench/tb_clock.sv */
// Testbench clock and reset generator, 40 ns period with reset held for five cycles
`timescale 1ns/1ps

module tb_clock (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;  // Half of the 40 ns period
  end

  // Reset drops on a falling edge like every other DUT input
  initial begin
    rst = 1'b1;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
  end

endmodule

/* bench/tb_icache.sv */
// Instruction cache testbench running fetch vectors against a burst memory model with random delays
`timescale 1ns/1ps

module tb_icache;

  localparam int NUM_VEC        = 20;               // Vector lines in the data file
  localparam int TIMEOUT_CYCLES = 20 * NUM_VEC + 50;
  localparam logic [31:0] DATA_KEY = 32'h094539c8;  // Memory word is its address XOR this key

  logic              clk;
  logic              rst;
  logic              cpu_req_valid;
  icache_pkg::addr_t cpu_req_addr;
  logic              cpu_req_ready;
  logic              cpu_rsp_valid;
  icache_pkg::word_t cpu_rsp_data;
  logic              mem_req_valid;
  icache_pkg::addr_t mem_req_addr;
  logic              mem_req_ready;
  logic              mem_rsp_valid;
  icache_pkg::word_t mem_rsp_data;
  logic              mem_rsp_last;
  logic              mem_rsp_ready;

  logic [31:0]       vec_raw [3*NUM_VEC];  // Address, word and hit flag per vector
  icache_pkg::addr_t vec_addr [NUM_VEC];
  icache_pkg::word_t vec_word [NUM_VEC];
  bit                vec_hit [NUM_VEC];
  int                cycle_count = 0;

  tb_clock i_clock (.clk(clk), .rst(rst));

  icache_top i_dut (
    .clk           (clk),
    .rst           (rst),
    .cpu_req_valid (cpu_req_valid),
    .cpu_req_addr  (cpu_req_addr),
    .cpu_req_ready (cpu_req_ready),
    .cpu_rsp_valid (cpu_rsp_valid),
    .cpu_rsp_data  (cpu_rsp_data),
    .mem_req_valid (mem_req_valid),
    .mem_req_addr  (mem_req_addr),
    .mem_req_ready (mem_req_ready),
    .mem_rsp_valid (mem_rsp_valid),
    .mem_rsp_data  (mem_rsp_data),
    .mem_rsp_last  (mem_rsp_last),
    .mem_rsp_ready (mem_rsp_ready)
  );

  // --------------------
  // Checks
  // --------------------
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input icache_pkg::word_t got,
                            input icache_pkg::word_t exp);
    if (got !== exp) abort_run($sformatf("mismatch at %0t: %s got %h expected %h",
                                         $time, name, got, exp));
  endtask

  task automatic check_addr(input string name, input icache_pkg::addr_t got,
                            input icache_pkg::addr_t exp);
    if (got !== exp) abort_run($sformatf("mismatch at %0t: %s got %h expected %h",
                                         $time, name, got, exp));
  endtask

  task automatic check_flag(input string name, input bit got, input bit exp);
    if (got !== exp) abort_run($sformatf("mismatch at %0t: %s got %b expected %b",
                                         $time, name, got, exp));
  endtask

  // Reference memory contents, each word is keyed by its own byte address
  function automatic icache_pkg::word_t mem_word(input icache_pkg::addr_t addr);
    return addr ^ DATA_KEY;
  endfunction

  always @(posedge clk) begin
    cycle_count++;  // Counts reset cycles too
    if (cycle_count >= TIMEOUT_CYCLES)
      abort_run($sformatf("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES));
  end

  // --------------------
  // Memory model
  // --------------------
  initial begin : memory_model
    icache_pkg::addr_t line_addr;
    int                gap;
    void'($urandom(32'h094539c8));  // All random delays are drawn in this process
    forever begin
      @(negedge clk);
      if (!rst && mem_req_valid) begin
        line_addr = mem_req_addr;
        // A line covers 32 bytes, so the request must sit on a 32-byte boundary
        check_addr("mem_req_addr", mem_req_addr, cpu_req_addr & ~32'h0000_001f);
        gap = $urandom_range(0, 3);
        repeat (gap) @(negedge clk);
        mem_req_ready = 1'b1;  // Taken at the next rising edge
        @(negedge clk);
        mem_req_ready = 1'b0;
        for (int k = 0; k < icache_pkg::LINE_WORDS; k++) begin
          gap = $urandom_range(0, 2);  // Idle cycles before this beat
          repeat (gap) @(negedge clk);
          if (!mem_rsp_ready) abort_run("memory beat offered while the cache was not refilling");
          mem_rsp_valid = 1'b1;
          mem_rsp_data  = mem_word(line_addr + 32'(4 * k));  // Beat k is word k of the line
          mem_rsp_last  = (k == icache_pkg::LINE_WORDS - 1);
          @(negedge clk);
          mem_rsp_valid = 1'b0;
          mem_rsp_last  = 1'b0;
        end
      end
    end
  end

  // --------------------
  // CPU driver
  // --------------------
  initial begin : cpu_driver
    bit saw_miss;
    int wait_cycles;
    cpu_req_valid = 1'b0;
    cpu_req_addr  = '0;
    mem_req_ready = 1'b0;
    mem_rsp_valid = 1'b0;
    mem_rsp_data  = '0;
    mem_rsp_last  = 1'b0;
    $readmemh("bench/icache_vectors.txt", vec_raw);
    for (int i = 0; i < NUM_VEC; i++) begin
      vec_addr[i] = vec_raw[3*i];
      vec_word[i] = vec_raw[3*i+1];
      vec_hit[i]  = vec_raw[3*i+2][0];  // Only the low bit carries the flag
    end
    wait (!rst);
    @(negedge clk);
    #10;  // Outputs sampled a quarter period after the falling edge
    check_flag("cpu_req_ready", cpu_req_ready, 1'b1);
    check_flag("mem_req_valid", mem_req_valid, 1'b0);
    check_flag("mem_rsp_ready", mem_rsp_ready, 1'b0);
    check_flag("cpu_rsp_valid", cpu_rsp_valid, 1'b0);
    for (int i = 0; i < NUM_VEC; i++) begin
      @(negedge clk);
      cpu_req_valid = 1'b1;
      cpu_req_addr  = vec_addr[i];  // Held until the response is seen
      saw_miss      = 1'b0;
      wait_cycles   = 0;
      #10;
      // A miss shows up as a memory request somewhere before the response
      while (!cpu_rsp_valid) begin
        if (mem_req_valid) saw_miss = 1'b1;
        @(negedge clk);
        #10;
        wait_cycles++;
      end
      check_word("cpu_rsp_data", cpu_rsp_data, vec_word[i]);
      check_flag("hit", !saw_miss, vec_hit[i]);
      check_flag("same_cycle_rsp", wait_cycles == 0, vec_hit[i]);  // Hits answer at once
    end
    @(negedge clk);
    cpu_req_valid = 1'b0;
    $display("Testbench passed");
    $finish;
  end

endmodule

/* bench/icache_vectors.txt */
// Columns: fetch address, expected instruction word, expected hit flag (1 hit, 0 miss)
// Set 0 warms up first, then set 2 gets seven tags to force an eviction
00000100 094538c8 0
0000011c 094538d4 1
00000108 094538c0 1
00001040 09452988 0
00002044 0945198c 0
00003048 09450980 0
0000404c 09457984 0
00005050 09456998 0
00006054 0945599c 0
00001058 09452990 1
00002040 09451988 1
0000705c 09454994 0
00003040 09450988 0
00001040 09452988 1
00007040 09454988 1
00005050 09456998 1
00006054 0945599c 1
00002048 09451980 1
00004040 09457988 0
00000100 094538c8 1

/* flist.f */
rtl/icache_pkg.sv
rtl/icache_tag_store.sv
rtl/icache_line_store.sv
rtl/icache_lru.sv
rtl/icache_refill_ctrl.sv
rtl/icache_top.sv
bench/tb_clock.sv
bench/tb_icache.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_icache -f flist.f > build.log 2>&1 ||
  { echo "Verilator build failed, see build.log"; exit 1; }
./obj_dir/Vtb_icache > sim.log 2>&1
grep -q "^Testbench passed$" sim.log && echo "Simulation PASS" ||
  { echo "Simulation FAIL, see sim.log"; exit 1; }
